/* hw/tetris_cfg.svh */
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

// playing field
`define TETRIS_ROWS      12
`define TETRIS_COLS      10
`define TETRIS_CELL_W    3   // colour bits, 0 is empty

// piece window, anchored at its top-left cell
`define TETRIS_WIN       5
`define TETRIS_SPAWN_ROW 0
`define TETRIS_SPAWN_COL 3
`define TETRIS_POS_W     6   // signed anchor row/col

`endif

/* hw/piece_pkg.sv */
`include "tetris_cfg.svh"

package piece_pkg;

  typedef enum logic [2:0] {
    A1 = 3'd0,
    A2 = 3'd1,
    B1 = 3'd2,
    B2 = 3'd3,
    C1 = 3'd4   // flat bar only
  } state_t;

  typedef enum logic [2:0] {
    NONE  = 3'd0,
    RIGHT = 3'd1,  // column - 1
    LEFT  = 3'd2,  // column + 1
    ROR   = 3'd3,
    ROL   = 3'd4,
    DOWN  = 3'd5
  } move_t;

  typedef enum logic [1:0] {
    SHAPE_A = 2'd0,
    SHAPE_B = 2'd1,
    SHAPE_C = 2'd2
  } shape_t;

  //////////////////////////////
  // command word, bit 7 set means spawn
  typedef struct packed {
    logic       op;
    move_t      move;
    logic [3:0] rsvd;
  } move_cmd_t;

  typedef struct packed {
    logic                      op;
    shape_t                    shape;
    logic [`TETRIS_CELL_W-1:0] color;
    logic [1:0]                rsvd;
  } spawn_cmd_t;

  typedef union packed {
    move_cmd_t  mv;
    spawn_cmd_t sp;
  } cmd_u;

endpackage

/* hw/board_pkg.sv */
`include "tetris_cfg.svh"

package board_pkg;

  typedef logic [`TETRIS_CELL_W-1:0] cell_t;

  // window indexed [row][col]
  typedef cell_t [`TETRIS_WIN-1:0][`TETRIS_WIN-1:0] frame_t;

  // one grid row, column 0 in the low bits
  typedef cell_t [`TETRIS_COLS-1:0] row_t;

endpackage

/* hw/tracker.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tracker (
  input  piece_pkg::state_t state_i,
  input  board_pkg::frame_t frame_i,
  input  piece_pkg::move_t  move_i,
  input  board_pkg::cell_t  color_i,
  output board_pkg::frame_t frame_o,
  output logic              complete_o
);

  localparam int WIN = `TETRIS_WIN;

  logic [WIN-1:0][WIN-1:0] need;  // cells to fill, must be empty
  logic [WIN-1:0][WIN-1:0] clr;   // cells the piece leaves
  logic                    legal;
  logic                    free;

  function automatic logic [WIN-1:0][WIN-1:0] pos(input int r, input int c);
    logic [WIN-1:0][WIN-1:0] m;
    m = '0;
    m[r][c] = 1'b1;
    return m;
  endfunction

  //////////////////////////////
  // move table
  always_comb begin
    need  = '0;
    clr   = '0;
    legal = 1'b1;
    case (state_i)
      piece_pkg::A1: begin
        case (move_i)
          piece_pkg::RIGHT: begin
            need = pos(1, 1) | pos(2, 0);
            clr  = pos(1, 3) | pos(2, 2);
          end
          piece_pkg::LEFT: begin
            need = pos(1, 4) | pos(2, 3);
            clr  = pos(1, 2) | pos(2, 1);
          end
          piece_pkg::ROR, piece_pkg::ROL: begin
            need = pos(1, 1) | pos(3, 2);
            clr  = pos(1, 2) | pos(1, 3);
          end
          piece_pkg::DOWN: begin
            need = pos(2, 3) | pos(3, 1) | pos(3, 2);
            clr  = pos(1, 2) | pos(1, 3) | pos(2, 1);
          end
          default: legal = 1'b0;
        endcase
      end
      piece_pkg::A2: begin
        case (move_i)
          piece_pkg::RIGHT: begin
            need = pos(1, 0) | pos(2, 0) | pos(3, 1);
            clr  = pos(1, 1) | pos(2, 2) | pos(3, 2);
          end
          piece_pkg::LEFT: begin
            need = pos(1, 2) | pos(2, 3) | pos(3, 3);
            clr  = pos(1, 1) | pos(2, 1) | pos(3, 2);
          end
          piece_pkg::ROR, piece_pkg::ROL: begin
            need = pos(1, 2) | pos(1, 3);
            clr  = pos(1, 1) | pos(3, 2);
          end
          piece_pkg::DOWN: begin
            need = pos(3, 1) | pos(4, 2);
            clr  = pos(1, 1) | pos(2, 2);
          end
          default: legal = 1'b0;
        endcase
      end
      piece_pkg::B1: begin
        case (move_i)
          piece_pkg::RIGHT: begin
            need = pos(1, 0) | pos(2, 1);
            clr  = pos(1, 2) | pos(2, 3);
          end
          piece_pkg::LEFT: begin
            need = pos(1, 3) | pos(2, 4);
            clr  = pos(1, 1) | pos(2, 2);
          end
          piece_pkg::ROR, piece_pkg::ROL: begin
            need = pos(2, 1) | pos(3, 1);
            clr  = pos(1, 1) | pos(2, 3);
          end
          piece_pkg::DOWN: begin
            need = pos(2, 1) | pos(3, 2) | pos(3, 3);
            clr  = pos(1, 1) | pos(1, 2) | pos(2, 3);
          end
          default: legal = 1'b0;
        endcase
      end
      piece_pkg::B2: begin
        case (move_i)
          piece_pkg::RIGHT: begin
            need = pos(1, 1) | pos(2, 0) | pos(3, 0);
            clr  = pos(1, 2) | pos(2, 2) | pos(3, 1);
          end
          piece_pkg::LEFT: begin
            need = pos(1, 3) | pos(2, 3) | pos(3, 2);
            clr  = pos(1, 2) | pos(2, 1) | pos(3, 1);
          end
          piece_pkg::ROR, piece_pkg::ROL: begin
            need = pos(1, 1) | pos(2, 3);
            clr  = pos(2, 1) | pos(3, 1);
          end
          piece_pkg::DOWN: begin
            need = pos(3, 2) | pos(4, 1);
            clr  = pos(1, 2) | pos(2, 1);
          end
          default: legal = 1'b0;
        endcase
      end
      piece_pkg::C1: begin
        case (move_i)
          piece_pkg::RIGHT: begin
            need = pos(1, 0);
            clr  = pos(1, 4);
          end
          // window fetched one column further along for this one
          piece_pkg::LEFT: begin
            need = pos(1, 4);
            clr  = pos(1, 0);
          end
          piece_pkg::DOWN: begin
            need = pos(2, 1) | pos(2, 2) | pos(2, 3) | pos(2, 4);
            clr  = pos(1, 1) | pos(1, 2) | pos(1, 3) | pos(1, 4);
          end
          default: legal = 1'b0;  // no upright bar
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    free = 1'b1;
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        if (need[r][c] && frame_i[r][c] != '0) free = 1'b0;
      end
    end
  end

  assign complete_o = legal && free;

  always_comb begin
    frame_o = frame_i;
    if (complete_o) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN; c++) begin
          if (clr[r][c]) frame_o[r][c] = '0;
          if (need[r][c]) frame_o[r][c] = color_i;
        end
      end
    end
  end

endmodule

/* hw/board_store.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module board_store (
  input  logic                                  clk,
  input  logic                                  rst_n_i,
  input  logic signed [`TETRIS_POS_W-1:0]       win_row_i,
  input  logic signed [`TETRIS_POS_W-1:0]       win_col_i,
  output board_pkg::frame_t                     frame_o,
  input  logic                                  wr_en_i,
  input  board_pkg::frame_t                     frame_i,
  input  logic [$clog2(`TETRIS_ROWS)-1:0]       rd_row_i,
  output board_pkg::row_t                       rd_data_o
);

  localparam int ROWS = `TETRIS_ROWS;
  localparam int COLS = `TETRIS_COLS;
  localparam int WIN  = `TETRIS_WIN;
  localparam int RAW  = $clog2(ROWS);
  localparam int CAW  = $clog2(COLS);

  board_pkg::row_t grid_q [ROWS];

  logic [WIN-1:0] row_ok;
  logic [WIN-1:0] col_ok;
  logic [RAW-1:0] row_idx [WIN];
  logic [CAW-1:0] col_idx [WIN];

  //////////////////////////////
  // window to grid mapping
  for (genvar i = 0; i < WIN; i++) begin : g_pos
    int r_abs;
    int c_abs;
    assign r_abs      = int'(win_row_i) + i;
    assign c_abs      = int'(win_col_i) + i;
    assign row_ok[i]  = (r_abs >= 0) && (r_abs < ROWS);
    assign col_ok[i]  = (c_abs >= 0) && (c_abs < COLS);
    assign row_idx[i] = r_abs[RAW-1:0];
    assign col_idx[i] = c_abs[CAW-1:0];
  end

  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        if (row_ok[r] && col_ok[c]) begin
          frame_o[r][c] = grid_q[row_idx[r]][col_idx[c]];
        end else begin
          frame_o[r][c] = '1;  // wall
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int r = 0; r < ROWS; r++) grid_q[r] <= '0;
    end else if (wr_en_i) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN; c++) begin
          if (row_ok[r] && col_ok[c]) grid_q[row_idx[r]][col_idx[c]] <= frame_i[r][c];
        end
      end
    end
  end

  // observation port
  assign rd_data_o = (int'(rd_row_i) < ROWS) ? grid_q[rd_row_i] : '0;

endmodule

/* hw/piece_ctrl.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module piece_ctrl (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            cmd_valid_i,
  output logic                            cmd_ready_o,
  input  piece_pkg::cmd_u                 cmd_i,
  output logic                            res_valid_o,
  input  logic                            res_ready_i,
  output logic                            res_ok_o,
  output logic signed [`TETRIS_POS_W-1:0] win_row_o,
  output logic signed [`TETRIS_POS_W-1:0] win_col_o,
  input  board_pkg::frame_t               frame_i,
  output board_pkg::frame_t               frame_o,
  output logic                            wr_en_o,
  output piece_pkg::state_t               trk_state_o,
  output piece_pkg::move_t                trk_move_o,
  output board_pkg::cell_t                trk_color_o,
  output board_pkg::frame_t               trk_frame_o,
  input  board_pkg::frame_t               trk_frame_i,
  input  logic                            trk_complete_i
);

  localparam int WIN   = `TETRIS_WIN;
  localparam int POS_W = `TETRIS_POS_W;

  typedef enum logic [1:0] {IDLE, FETCH, APPLY, RESP} fsm_t;

  fsm_t              fsm_q;
  piece_pkg::cmd_u   cmd_q;
  board_pkg::frame_t frame_q;
  logic              res_ok_q;

  // active piece
  logic                    present_q;
  piece_pkg::state_t       state_q;
  logic signed [POS_W-1:0] row_q;
  logic signed [POS_W-1:0] col_q;
  board_pkg::cell_t        color_q;

  logic                    is_spawn;
  logic [WIN-1:0][WIN-1:0] sp_mask;
  logic                    sp_valid;
  logic                    sp_free;
  piece_pkg::state_t       sp_state;
  board_pkg::frame_t       sp_frame;
  logic                    apply_ok;

  assign is_spawn = cmd_q.sp.op;

  //////////////////////////////
  // spawn layouts at the spawn anchor
  always_comb begin
    sp_mask  = '0;
    sp_valid = 1'b1;
    sp_state = piece_pkg::A1;
    case (cmd_q.sp.shape)
      piece_pkg::SHAPE_A: begin
        sp_mask[1][3:2] = 2'b11;
        sp_mask[2][2:1] = 2'b11;
      end
      piece_pkg::SHAPE_B: begin
        sp_state        = piece_pkg::B1;
        sp_mask[1][2:1] = 2'b11;
        sp_mask[2][3:2] = 2'b11;
      end
      piece_pkg::SHAPE_C: begin
        sp_state        = piece_pkg::C1;
        sp_mask[1][4:1] = 4'b1111;
      end
      default: sp_valid = 1'b0;
    endcase
  end

  always_comb begin
    sp_free  = 1'b1;
    sp_frame = frame_q;
    for (int r = 0; r < WIN; r++) begin
      for (int c = 0; c < WIN; c++) begin
        if (sp_mask[r][c]) begin
          if (frame_q[r][c] != '0) sp_free = 1'b0;
          sp_frame[r][c] = cmd_q.sp.color;
        end
      end
    end
  end

  always_comb begin
    win_row_o = row_q;
    win_col_o = col_q;
    if (is_spawn) begin
      win_row_o = POS_W'(`TETRIS_SPAWN_ROW);
      win_col_o = POS_W'(`TETRIS_SPAWN_COL);
    end else if (state_q == piece_pkg::C1 && cmd_q.mv.move == piece_pkg::LEFT) begin
      win_col_o = col_q + POS_W'(1);  // bar fills the window width
    end
  end

  assign apply_ok    = is_spawn ? (sp_valid && sp_free) : (present_q && trk_complete_i);
  assign wr_en_o     = (fsm_q == APPLY) && apply_ok;
  assign frame_o     = is_spawn ? sp_frame : trk_frame_i;
  assign trk_state_o = state_q;
  assign trk_move_o  = is_spawn ? piece_pkg::NONE : cmd_q.mv.move;
  assign trk_color_o = color_q;
  assign trk_frame_o = frame_q;

  assign cmd_ready_o = (fsm_q == IDLE);
  assign res_valid_o = (fsm_q == RESP);
  assign res_ok_o    = res_ok_q;

  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      fsm_q     <= IDLE;
      present_q <= 1'b0;
    end else begin
      case (fsm_q)
        IDLE:  if (cmd_valid_i) fsm_q <= FETCH;
        FETCH: fsm_q <= APPLY;
        APPLY: begin
          fsm_q <= RESP;
          if (is_spawn && apply_ok) present_q <= 1'b1;
        end
        RESP:  if (res_ready_i) fsm_q <= IDLE;
        default: fsm_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid_i && cmd_ready_o) cmd_q <= cmd_i;
    if (fsm_q == FETCH) frame_q <= frame_i;
    if (fsm_q == APPLY) begin
      res_ok_q <= apply_ok;
      if (apply_ok && is_spawn) begin
        state_q <= sp_state;
        row_q   <= POS_W'(`TETRIS_SPAWN_ROW);
        col_q   <= POS_W'(`TETRIS_SPAWN_COL);
        color_q <= cmd_q.sp.color;
      end else if (apply_ok) begin
        case (cmd_q.mv.move)
          piece_pkg::RIGHT: col_q <= col_q - POS_W'(1);
          piece_pkg::LEFT:  col_q <= col_q + POS_W'(1);
          piece_pkg::DOWN:  row_q <= row_q + POS_W'(1);
          piece_pkg::ROR, piece_pkg::ROL: begin
            case (state_q)
              piece_pkg::A1: state_q <= piece_pkg::A2;
              piece_pkg::A2: state_q <= piece_pkg::A1;
              piece_pkg::B1: state_q <= piece_pkg::B2;
              piece_pkg::B2: state_q <= piece_pkg::B1;
              default:       state_q <= state_q;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* hw/tetris_top.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tetris_top (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            cmd_valid_i,
  output logic                            cmd_ready_o,
  input  piece_pkg::cmd_u                 cmd_i,
  output logic                            res_valid_o,
  input  logic                            res_ready_i,
  output logic                            res_ok_o,
  input  logic [$clog2(`TETRIS_ROWS)-1:0] rd_row_i,
  output board_pkg::row_t                 rd_data_o
);

  logic signed [`TETRIS_POS_W-1:0] win_row;
  logic signed [`TETRIS_POS_W-1:0] win_col;
  board_pkg::frame_t               frame;     // store to ctrl
  board_pkg::frame_t               wr_frame;  // ctrl to store
  logic                            wr_en;

  // tracker side
  piece_pkg::state_t trk_state;
  piece_pkg::move_t  trk_move;
  board_pkg::cell_t  trk_color;
  board_pkg::frame_t trk_frame_in;
  board_pkg::frame_t trk_frame_out;
  logic              complete;

  piece_ctrl u_ctrl (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_i          (cmd_i),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_ok_o       (res_ok_o),
    .win_row_o      (win_row),
    .win_col_o      (win_col),
    .frame_i        (frame),
    .frame_o        (wr_frame),
    .wr_en_o        (wr_en),
    .trk_state_o    (trk_state),
    .trk_move_o     (trk_move),
    .trk_color_o    (trk_color),
    .trk_frame_o    (trk_frame_in),
    .trk_frame_i    (trk_frame_out),
    .trk_complete_i (complete)
  );

  board_store u_store (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .win_row_i (win_row),
    .win_col_i (win_col),
    .frame_o   (frame),
    .wr_en_i   (wr_en),
    .frame_i   (wr_frame),
    .rd_row_i  (rd_row_i),
    .rd_data_o (rd_data_o)
  );

  tracker u_tracker (
    .state_i    (trk_state),
    .frame_i    (trk_frame_in),
    .move_i     (trk_move),
    .color_i    (trk_color),
    .frame_o    (trk_frame_out),
    .complete_o (complete)
  );

endmodule

/* tb/tetris_chk.sv */
`timescale 1ns/1ps

module tetris_chk (
  input logic clk,
  input logic rst_n_i,
  input logic cmd_ready_i,
  input logic res_valid_i,
  input logic res_ready_i,
  input logic res_ok_i
);

  int fail_cnt = 0;  // failed assertions so far

  //////////////////////////////
  // result handshake
  a_busy_while_result: assert property (
    @(posedge clk) disable iff (!rst_n_i) res_valid_i |-> !cmd_ready_i
  ) else begin
    fail_cnt++;
    $error("cmd_ready_o is high while a result is pending");
  end

  a_result_held: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_ok_i))
  ) else begin
    fail_cnt++;
    $error("stalled result was dropped or changed");
  end

  // nothing to report straight out of reset
  a_reset_idle: assert property (
    @(posedge clk) !rst_n_i |=> !res_valid_i
  ) else begin
    fail_cnt++;
    $error("res_valid_o high after reset");
  end

endmodule

bind tetris_top tetris_chk u_chk (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .cmd_ready_i (cmd_ready_o),
  .res_valid_i (res_valid_o),
  .res_ready_i (res_ready_i),
  .res_ok_i    (res_ok_o)
);

/* tb/tetris_tb.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tetris_tb;

  localparam int RA_W  = $clog2(`TETRIS_ROWS);
  localparam int ROW_W = `TETRIS_COLS * `TETRIS_CELL_W;

  logic            clk;
  logic            rst_n_i;
  logic            cmd_valid_i;
  logic            cmd_ready_o;
  piece_pkg::cmd_u cmd_i;
  logic            res_valid_o;
  logic            res_ready_i;
  logic            res_ok_o;
  logic [RA_W-1:0] rd_row_i;
  board_pkg::row_t rd_data_o;

  logic [7:0]      gold_cmd  [$];
  logic            gold_ok   [$];
  logic [RA_W-1:0] gold_row  [$];
  board_pkg::row_t gold_data [$];

  logic [31:0] rng_q;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  tetris_top u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_ok_o    (res_ok_o),
    .rd_row_i    (rd_row_i),
    .rd_data_o   (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped on first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_golden();
    int               fd;
    int               n;
    int               ok;
    int               row;
    string            line;
    logic [7:0]       cmd;
    logic [ROW_W-1:0] data;
    fd = $fopen("tb/tetris_golden.txt", "r");
    if (fd == 0) begin
      report_failure("could not open tb/tetris_golden.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line[0] == "#") continue;  // comments, blank lines
        n = $sscanf(line, "%h %d %d %h", cmd, ok, row, data);
        if (n != 4) begin
          report_failure({"badly formed golden line: ", line});
        end else begin
          gold_cmd.push_back(cmd);
          gold_ok.push_back(ok != 0);
          gold_row.push_back(RA_W'(row));
          gold_data.push_back(data);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_state();
    assert (!res_valid_o && cmd_ready_o)
      else report_failure($sformatf("Mismatch at %0t: handshake not idle after reset", $time));
    for (int r = 0; r < `TETRIS_ROWS; r++) begin
      rd_row_i <= RA_W'(r);
      @(posedge clk);
      assert (rd_data_o == '0)
        else report_failure($sformatf("Mismatch at %0t: row %0d reads %h after reset",
                                      $time, r, rd_data_o));
    end
  endtask

  task automatic run_command(input int idx);
    int   lat;
    int   stall;
    logic ok_seen;
    cmd_i       <= piece_pkg::cmd_u'(gold_cmd[idx]);
    cmd_valid_i <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(cmd_valid_i && cmd_ready_o));
    cmd_valid_i <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!res_valid_o);
    assert (lat == 3)
      else report_failure($sformatf("Mismatch at %0t: command %0d result after %0d cycles",
                                    $time, idx, lat));
    assert (res_ok_o == gold_ok[idx])
      else report_failure($sformatf("Mismatch at %0t: command %0d ok %0b, expected %0b",
                                    $time, idx, res_ok_o, gold_ok[idx]));
    ok_seen  = res_ok_o;
    rng_q    = xorshift32(rng_q);
    stall    = int'(rng_q[1:0]);
    rd_row_i <= gold_row[idx];
    // next command waits on the pending result
    if (idx + 1 < gold_cmd.size()) begin
      cmd_i       <= piece_pkg::cmd_u'(gold_cmd[idx + 1]);
      cmd_valid_i <= 1'b1;
    end
    repeat (stall) begin
      @(posedge clk);
      assert (res_valid_o && res_ok_o == ok_seen && !cmd_ready_o)
        else report_failure($sformatf("Mismatch at %0t: command %0d result not held",
                                      $time, idx));
    end
    res_ready_i <= 1'b1;
    @(posedge clk);
    assert (res_valid_o && !cmd_ready_o)
      else report_failure($sformatf("Mismatch at %0t: command %0d lost its result", $time, idx));
    assert (rd_data_o == gold_data[idx])
      else report_failure($sformatf("Mismatch at %0t: row %0d reads %h, expected %h",
                                    $time, gold_row[idx], rd_data_o, gold_data[idx]));
    res_ready_i <= 1'b0;
  endtask

  //////////////////////////////
  initial begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
      if (u_dut.u_chk.fail_cnt != 0) begin
        report_failure("a bound handshake assertion failed");
      end
    end
    report_failure($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
  end

  initial begin
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    res_ready_i = 1'b0;
    rd_row_i    = '0;
    rng_q       = 32'd57907;
    load_golden();
    // accept, latency, worst stall plus handshake per command
    cycle_limit = gold_cmd.size() * (3 + 3 + 4) + 50;
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    check_reset_state();
    for (int i = 0; i < gold_cmd.size(); i++) begin
      run_command(i);
    end
    if (u_dut.u_chk.fail_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("handshake checker flagged %0d assertion failures", u_dut.u_chk.fail_cnt);
      $display("Test failures found");
      $fatal(1, "assertion failures in the handshake checker");
    end
  end

endmodule

/* build.f */
+incdir+hw
hw/piece_pkg.sv
hw/board_pkg.sv
hw/tracker.sv
hw/board_store.sv
hw/piece_ctrl.sv
hw/tetris_top.sv
tb/tetris_chk.sv
tb/tetris_tb.sv

/* Makefile */
TOP := tetris_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tetris_golden.txt */
# cmd ok row data: cmd is the command word (hex), ok the expected result,
# row the grid row read back afterwards, data that row packed with column 0 in the low bits (hex)
50 0 1 00000000
8c 1 1 000d8000
10 1 1 0001b000
10 1 2 000006c0
10 1 2 000000d8
10 1 2 0000001b
10 0 2 0000001b
20 1 1 000006c0
30 1 1 00000018
50 1 3 000000d8
40 1 2 000006c0
# second piece, the first one stays as debris
b4 1 2 001686c0
10 1 2 0002d6c0
10 0 2 0002d6c0
20 1 1 0002d000
30 1 3 000050d8
40 1 3 000000d8
50 1 3 001680d8
88 0 2 0002d6c0
# flat bar
d8 1 1 00db6000
30 0 1 00db6000
20 1 1 06db0000
20 1 1 36d80000
20 0 1 36d80000
50 1 2 36dad6c0
50 0 2 36dad6c0
10 0 2 36dad6c0
